//--- hdl/uart_frame_pkg.sv
package uart_frame_pkg;

    // parity kind carried by the frame
    typedef enum logic {
        PARITY_EVEN = 1'b0, // parity bit makes the count of ones even
        PARITY_ODD  = 1'b1  // parity bit makes the count of ones odd
    } parity_e;

    // data bits per frame unless the top level says otherwise
    localparam int DEFAULT_DATA_WIDTH = 8;

    // bits in a frame besides the data bits
    localparam int START_BITS  = 1;
    localparam int PARITY_BITS = 1;
    localparam int STOP_BITS   = 1;

    // total bit periods in one frame: start, data, parity and stop
    function automatic int frame_bits(input int data_width);
        return data_width + START_BITS + PARITY_BITS + STOP_BITS;
    endfunction

endpackage

//--- hdl/uart_timing_pkg.sv
package uart_timing_pkg;

    // clock cycles per bit period unless the top level says otherwise
    localparam int DEFAULT_CLKS_PER_BIT = 16;

    // flip-flops in the synchronizer on the serial input
    localparam int SYNC_STAGES = 2;

endpackage

//--- hdl/rx_sampler.sv
module rx_sampler #(
    parameter int CLKS_PER_BIT = uart_timing_pkg::DEFAULT_CLKS_PER_BIT
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    input  logic frame_done,
    output logic sampling_strobe,
    output logic start_detected,
    output logic sample_bit
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_PERIOD = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_PERIOD = CNT_W'(CLKS_PER_BIT - 1);

    logic [uart_timing_pkg::SYNC_STAGES-1:0] sync_q; // metastability chain
    logic                                    line_sync;
    logic                                    line_q;  // edge register
    logic                                    line_fall;
    logic                                    armed;   // low while hunting
    logic [CNT_W-1:0]                        bit_cnt;

    assign line_sync = sync_q[uart_timing_pkg::SYNC_STAGES-1];
    assign line_fall = line_q & ~line_sync; // high to low on the synced line

    // the line idles high, so preset the chain to avoid a false edge out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= '1;
            line_q <= 1'b1;
        end else begin
            sync_q <= {sync_q[uart_timing_pkg::SYNC_STAGES-2:0], rx};
            line_q <= line_sync;
        end
    end

    // bit-centre strobe generator
    always_ff @(posedge clk) begin
        if (reset) begin
            armed           <= 1'b0;
            bit_cnt         <= '0;
            sampling_strobe <= 1'b0;
            start_detected  <= 1'b0;
        end else begin
            sampling_strobe <= 1'b0;
            start_detected  <= 1'b0;
            if (!armed) begin
                if (line_fall) begin
                    armed           <= 1'b1;
                    bit_cnt         <= HALF_PERIOD; // next strobe at start bit centre
                    sampling_strobe <= 1'b1;
                    start_detected  <= 1'b1;
                end
            end else if (frame_done) begin
                armed <= 1'b0; // back to hunting
            end else if (bit_cnt == '0) begin
                bit_cnt         <= FULL_PERIOD;
                sampling_strobe <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // line_q is updated on the strobe edge, so it holds the centre sample
    assign sample_bit = line_q;

endmodule

//--- hdl/rx_state.sv
module rx_state #(
    parameter int DATA_WIDTH = uart_frame_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic clk,
    input  logic reset,
    input  logic start_detected,
    input  logic sampling_strobe,
    output logic data_is_available,
    output logic data_is_valid,
    output logic is_parity_stage
);

    // one extra code so the stop state always fits
    localparam int STATE_W = $clog2(uart_frame_pkg::frame_bits(DATA_WIDTH) + 1);

    localparam logic [STATE_W-1:0] ST_IDLE       = STATE_W'(0);
    localparam logic [STATE_W-1:0] ST_START      = STATE_W'(1);
    localparam logic [STATE_W-1:0] ST_DATA_FIRST = STATE_W'(2);
    localparam logic [STATE_W-1:0] ST_DATA_LAST  = STATE_W'(DATA_WIDTH + 1);
    localparam logic [STATE_W-1:0] ST_PARITY     = STATE_W'(DATA_WIDTH + 2);
    localparam logic [STATE_W-1:0] ST_STOP       = STATE_W'(DATA_WIDTH + 3);

    logic [STATE_W-1:0] state;

    // phase flags lag the state by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            data_is_available <= 1'b0;
            is_parity_stage   <= 1'b0;
            data_is_valid     <= 1'b0;
        end else begin
            data_is_available <= (state >= ST_DATA_FIRST) && (state <= ST_DATA_LAST);
            is_parity_stage   <= (state == ST_PARITY);
            data_is_valid     <= (state == ST_STOP); // stop bit phase
        end
    end

    // frame sequence, advanced only on strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (sampling_strobe) begin
            case (state) inside
                ST_IDLE: begin
                    state <= start_detected ? ST_START : ST_IDLE;
                end
                ST_START: begin
                    state <= ST_DATA_FIRST;
                end
                [ST_DATA_FIRST:ST_DATA_LAST]: begin
                    state <= state + 1'b1; // last data state steps into parity
                end
                ST_PARITY: begin
                    state <= ST_STOP;
                end
                ST_STOP: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE; // unused codes recover
                end
            endcase
        end
    end

endmodule

//--- hdl/rx_deserializer.sv
module rx_deserializer #(
    parameter int                      DATA_WIDTH = uart_frame_pkg::DEFAULT_DATA_WIDTH,
    parameter uart_frame_pkg::parity_e PARITY     = uart_frame_pkg::PARITY_EVEN
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sampling_strobe,
    input  logic                  sample_bit,
    input  logic                  data_is_available,
    input  logic                  is_parity_stage,
    input  logic                  data_is_valid,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid,
    output logic                  parity_error,
    output logic                  framing_error,
    output logic                  frame_done
);

    localparam logic ODD_PARITY = (PARITY == uart_frame_pkg::PARITY_ODD);

    logic [DATA_WIDTH-1:0] shift_q;
    logic                  parity_acc;  // xor of data bits so far
    logic                  parity_bad;  // result of the parity compare
    logic                  expected_parity;
    logic                  valid_q;
    logic                  data_strobe;
    logic                  parity_strobe;
    logic                  stop_strobe;

    assign data_strobe     = sampling_strobe & data_is_available;
    assign parity_strobe   = sampling_strobe & is_parity_stage;
    assign stop_strobe     = sampling_strobe & data_is_valid;
    assign expected_parity = parity_acc ^ ODD_PARITY;

    // payload path
    always_ff @(posedge clk) begin
        if (data_strobe) begin
            shift_q <= {sample_bit, shift_q[DATA_WIDTH-1:1]}; // lsb first on the line
        end
        if (parity_strobe) begin
            parity_bad <= sample_bit ^ expected_parity;
        end
        if (stop_strobe) begin
            rx_data <= shift_q;
        end
    end

    // frame result, flags are pulses alongside rx_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            parity_acc    <= 1'b0;
            valid_q       <= 1'b0;
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            valid_q       <= 1'b0;
            parity_error  <= 1'b0;
            framing_error <= 1'b0;
            if (data_strobe) begin
                parity_acc <= parity_acc ^ sample_bit;
            end
            if (stop_strobe) begin
                valid_q       <= 1'b1;
                parity_error  <= parity_bad;
                framing_error <= ~sample_bit; // stop bit must be high
                parity_acc    <= 1'b0;        // ready for next frame
            end
        end
    end

    // the same pulse re-arms the sampler
    assign rx_valid   = valid_q;
    assign frame_done = valid_q;

endmodule

//--- hdl/uart_rx_top.sv
module uart_rx_top #(
    parameter int                      DATA_WIDTH   = uart_frame_pkg::DEFAULT_DATA_WIDTH,
    parameter int                      CLKS_PER_BIT = uart_timing_pkg::DEFAULT_CLKS_PER_BIT,
    parameter uart_frame_pkg::parity_e PARITY       = uart_frame_pkg::PARITY_EVEN
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx,
    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid,
    output logic                  parity_error,
    output logic                  framing_error
);

    logic sampling_strobe;
    logic start_detected;
    logic sample_bit;
    logic data_is_available;
    logic is_parity_stage;
    logic data_is_valid;
    logic frame_done;   // end of frame, re-arms the sampler

    rx_sampler #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx_sampler (
        .clk            (clk),
        .reset          (reset),
        .rx             (rx),
        .frame_done     (frame_done),
        .sampling_strobe(sampling_strobe),
        .start_detected (start_detected),
        .sample_bit     (sample_bit)
    );

    rx_state #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_rx_state (
        .clk              (clk),
        .reset            (reset),
        .start_detected   (start_detected),
        .sampling_strobe  (sampling_strobe),
        .data_is_available(data_is_available),
        .data_is_valid    (data_is_valid),
        .is_parity_stage  (is_parity_stage)
    );

    rx_deserializer #(
        .DATA_WIDTH(DATA_WIDTH),
        .PARITY    (PARITY)
    ) u_rx_deserializer (
        .clk              (clk),
        .reset            (reset),
        .sampling_strobe  (sampling_strobe),
        .sample_bit       (sample_bit),
        .data_is_available(data_is_available),
        .is_parity_stage  (is_parity_stage),
        .data_is_valid    (data_is_valid),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .parity_error     (parity_error),
        .framing_error    (framing_error),
        .frame_done       (frame_done)
    );

endmodule

//--- verification/uart_rx_tb.sv
module uart_rx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int                      CLK_PERIOD   = 40;
    localparam int                      CLKS_PER_BIT = 16;
    localparam int                      DATA_WIDTH   = 8;
    localparam uart_frame_pkg::parity_e PARITY       = uart_frame_pkg::PARITY_EVEN;

    localparam int RESET_CYCLES      = 4;
    localparam int IDLE_CHECK_CYCLES = 50;
    localparam int RANDOM_FRAMES     = 20;
    localparam int MAX_GAP           = 63;  // six random bits per gap
    localparam int PARITY_FRAMES     = 3;
    localparam int STOP_FRAMES       = 2;
    localparam int BURST_FRAMES      = 6;
    localparam int TOTAL_FRAMES      = RANDOM_FRAMES + PARITY_FRAMES + STOP_FRAMES + BURST_FRAMES;

    // one spare bit period per frame
    localparam int FRAME_CYCLES =
        (uart_frame_pkg::frame_bits(DATA_WIDTH) + 1) * CLKS_PER_BIT;
    // fixed gaps and end-of-test idle of tests 2 to 5 come to ten bit periods
    localparam int GAP_CYCLES = RESET_CYCLES + IDLE_CHECK_CYCLES
        + RANDOM_FRAMES * MAX_GAP + 10 * CLKS_PER_BIT;
    localparam int CYCLE_LIMIT = TOTAL_FRAMES * FRAME_CYCLES + GAP_CYCLES
        + uart_timing_pkg::SYNC_STAGES + 100;

    logic                  clk;
    logic                  reset;
    logic                  rx;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  rx_valid;
    logic                  parity_error;
    logic                  framing_error;

    logic [DATA_WIDTH-1:0] exp_data_q[$];  // expected words, oldest first
    logic                  exp_perr_q[$];
    logic                  exp_ferr_q[$];

    logic [31:0] lfsr_state;
    string       test_name;
    int          error_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;

    uart_rx_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PARITY      (PARITY)
    ) u_uart_rx_top (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .parity_error (parity_error),
        .framing_error(framing_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run passed %0d clock cycles before the tests finished",
                     CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0]; // taps 32 22 2 1
        return {state[30:0], feedback};
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]}; // one step per bit
        end
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("ERROR in %s: %s", test_name, what);
    endtask

    task automatic show_mismatch(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        error_count++;
        $display("FAILED %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic hold_line(input logic level, input int cycles);
        rx = level;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic send_frame(input logic [DATA_WIDTH-1:0] data, input logic flip_parity,
                              input logic stop_bit, input int gap);
        logic parity_bit;
        parity_bit = (^data) ^ (PARITY == uart_frame_pkg::PARITY_ODD) ^ flip_parity;
        exp_data_q.push_back(data);
        exp_perr_q.push_back(flip_parity);
        exp_ferr_q.push_back(~stop_bit);
        hold_line(1'b0, CLKS_PER_BIT); // start bit
        for (int i = 0; i < DATA_WIDTH; i++) begin
            hold_line(data[i], CLKS_PER_BIT); // lsb first
        end
        hold_line(parity_bit, CLKS_PER_BIT);
        hold_line(stop_bit, CLKS_PER_BIT);
        hold_line(1'b1, gap);
    endtask

    task automatic drain_expected();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            note_failure($sformatf("%0d frame(s) never produced rx_valid", exp_data_q.size()));
            exp_data_q.delete();
            exp_perr_q.delete();
            exp_ferr_q.delete();
        end
    endtask

    task automatic finish_test(input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d error(s)", test_name,
                     error_count - errors_before);
        end
    endtask

    // compare each received word with the oldest pending frame, mid-cycle
    always @(negedge clk) begin
        if (!reset && rx_valid) begin
            if (exp_data_q.size() == 0) begin
                note_failure("rx_valid pulsed with no frame pending");
            end else begin
                assert (rx_data == exp_data_q[0])
                    else show_mismatch("rx_data", exp_data_q[0], rx_data);
                assert (parity_error == exp_perr_q[0])
                    else show_mismatch("parity_error", exp_perr_q[0], parity_error);
                assert (framing_error == exp_ferr_q[0])
                    else show_mismatch("framing_error", exp_ferr_q[0], framing_error);
                exp_data_q.delete(0);
                exp_perr_q.delete(0);
                exp_ferr_q.delete(0);
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !rx_valid && !parity_error && !framing_error)
        else note_failure("output active while reset was held");

    // error flags only ride with rx_valid
    flags_with_valid: assert property (@(posedge clk) disable iff (reset)
        !rx_valid |-> !parity_error && !framing_error)
        else note_failure("error flag high without rx_valid");

    valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else note_failure("rx_valid stayed high for more than one cycle");

    initial begin
        logic [31:0]           rnd;
        logic [DATA_WIDTH-1:0] burst [BURST_FRAMES];
        int                    mark;

        reset      = 1'b1;
        rx         = 1'b1; // idle line
        lfsr_state = 32'h323b_609a;

        test_name = "reset_idle";
        mark      = error_count;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        hold_line(1'b1, IDLE_CHECK_CYCLES);
        finish_test(mark);

        test_name = "random_frames";
        mark      = error_count;
        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            take_random(DATA_WIDTH, rnd);
            burst[0] = rnd[DATA_WIDTH-1:0];
            take_random(6, rnd);
            send_frame(burst[0], 1'b0, 1'b1, int'(rnd[5:0]));
        end
        hold_line(1'b1, CLKS_PER_BIT);
        drain_expected();
        finish_test(mark);

        test_name = "bad_parity";
        mark      = error_count;
        for (int i = 0; i < PARITY_FRAMES; i++) begin
            take_random(DATA_WIDTH, rnd);
            send_frame(rnd[DATA_WIDTH-1:0], 1'b1, 1'b1, CLKS_PER_BIT);
        end
        hold_line(1'b1, CLKS_PER_BIT);
        drain_expected();
        finish_test(mark);

        // low stop bit, then a good frame once the line is high again
        test_name = "bad_stop_recover";
        mark      = error_count;
        take_random(DATA_WIDTH, rnd);
        send_frame(rnd[DATA_WIDTH-1:0], 1'b0, 1'b0, 2 * CLKS_PER_BIT);
        take_random(DATA_WIDTH, rnd);
        send_frame(rnd[DATA_WIDTH-1:0], 1'b0, 1'b1, CLKS_PER_BIT);
        hold_line(1'b1, CLKS_PER_BIT);
        drain_expected();
        finish_test(mark);

        test_name = "back_to_back";
        mark      = error_count;
        burst[0]  = 8'h00;
        burst[1]  = 8'hff;
        burst[2]  = 8'h55;
        burst[3]  = 8'ha5;
        for (int i = 4; i < BURST_FRAMES; i++) begin
            take_random(DATA_WIDTH, rnd);
            burst[i] = rnd[DATA_WIDTH-1:0];
        end
        for (int i = 0; i < BURST_FRAMES; i++) begin
            send_frame(burst[i], 1'b0, 1'b1, 0); // next start follows the stop bit
        end
        hold_line(1'b1, CLKS_PER_BIT);
        drain_expected();
        finish_test(mark);

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hdl/uart_frame_pkg.sv
hdl/uart_timing_pkg.sv
hdl/rx_sampler.sv
hdl/rx_state.sv
hdl/rx_deserializer.sv
hdl/uart_rx_top.sv
verification/uart_rx_tb.sv

//--- Bender.yml
package:
  name: uart_rx

sources:
  - files:
      - hdl/uart_frame_pkg.sv
      - hdl/uart_timing_pkg.sv
      - hdl/rx_sampler.sv
      - hdl/rx_state.sv
      - hdl/rx_deserializer.sv
      - hdl/uart_rx_top.sv

  - target: test
    files:
      - verification/uart_rx_tb.sv
